// ==== rx_params.svh ====
// completer-request receive engine parameters
// stream widths, request codes and throughput window length
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// stream and fifo word widths
`define RX_DATA_W        256      // full beat, also one fifo word
`define RX_HALF_W        128      // 4-DW half beat

// descriptor field widths
`define RX_DWCNT_W       11       // DW length field
`define RX_ADDR_W        11       // latched DW address

// request type codes from the descriptor
`define RX_TYPE_MEM_RD   4'd0
`define RX_TYPE_MEM_WR   4'd1

// throughput window
`define RX_WINDOW_CYCLES 25000000 // 100 ms at 250 MHz
`define RX_CNT_W         32

`endif

// ==== rx_pkg.sv ====
// completer-request receive types
// request descriptor, the two views of a stream beat and the FSM states
`default_nettype none

`include "rx_params.svh"

package rx_pkg;

  ////////////////////////////////////////////////////
  // 128-bit completer request descriptor, msb first
  ////////////////////////////////////////////////////
  typedef struct packed {
    logic                     rsvd_hi;    // bit 127
    logic [2:0]               attr;
    logic [2:0]               tc;
    logic [16:0]              rsvd_bar;   // bar aperture, bar id, target function
    logic [7:0]               tag;
    logic [15:0]              req_id;
    logic                     rsvd_79;
    logic [3:0]               req_type;
    logic [`RX_DWCNT_W-1:0]   dw_cnt;
    logic [61:0]              addr;       // DW address, low bits used
    logic [1:0]               addr_type;
  } cq_desc_t;

  // header beat: payload DW0..DW3 above the descriptor
  typedef struct packed {
    logic [`RX_HALF_W-1:0] payload;
    cq_desc_t              desc;
  } cq_hdr_beat_t;

  // continuation beat: two 4-DW halves
  typedef struct packed {
    logic [`RX_HALF_W-1:0] upper;
    logic [`RX_HALF_W-1:0] lower;
  } cq_body_beat_t;

  typedef union packed {
    cq_hdr_beat_t  hdr;
    cq_body_beat_t body;
  } cq_beat_u;

  ////////////////////////////////////////////////////
  // request FSM states
  ////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,        // waiting for a header beat
    READ_WAIT,   // completion pending, intake held off
    WRITE_BODY,  // continuation beats of a long write
    FLUSH,       // carried half goes out alone
    DISCARD      // unsupported request, drop to tlast
  } rx_state_e;

endpackage

`default_nettype wire

// ==== rx_pack_if.sv ====
// pack command link between the request FSM and the payload packer
// strobes and remaining DW count go one way, the word write comes back
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

interface rx_pack_if;

  logic                   load_first;  // write header on the stream
  logic                   load_body;   // write continuation beat
  logic                   flush;       // carry goes out alone
  logic [`RX_DWCNT_W-1:0] dw_left;     // payload DWs not yet written
  logic                   word_wr;     // registered fifo write

  modport ctrl (output load_first, output load_body, output flush, output dw_left,
                input word_wr);
  modport pack (input load_first, input load_body, input flush, input dw_left,
                output word_wr);

endinterface

`default_nettype wire

// ==== cq_rx_fsm.sv ====
// completer request FSM
// decodes header beats, latches the single-DW read descriptor, tracks the
// remaining write payload and drives tready and the pack strobes
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module cq_rx_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rx_pkg::cq_beat_u       beat_i,
  input  logic [7:0]             tuser_be_i,    // first/last DW byte enables
  input  logic                   tvalid_i,
  input  logic                   tlast_i,
  input  logic                   compl_done_i,
  output logic                   tready_o,
  output logic                   req_compl_o,
  output logic [`RX_ADDR_W-1:0]  req_addr_o,
  output logic [2:0]             req_tc_o,
  output logic [2:0]             req_attr_o,
  output logic [15:0]            req_rid_o,
  output logic [7:0]             req_tag_o,
  output logic [7:0]             req_be_o,
  rx_pack_if.ctrl                pack
);

  rx_pkg::rx_state_e      state_q;
  rx_pkg::rx_state_e      state_d;
  rx_pkg::cq_desc_t       desc;
  logic [`RX_DWCNT_W-1:0] dw_left_q;
  logic [`RX_DWCNT_W-1:0] dw_left_d;
  logic                   beat_ok;
  logic                   in_idle;
  logic                   is_wr;
  logic                   take_rd;
  logic                   hdr_short;

  ////////////////////////////////////////////////////
  // header decode, first view of the beat
  ////////////////////////////////////////////////////
  assign desc      = beat_i.hdr.desc;
  assign beat_ok   = tvalid_i & tready_o;           // beat moves this cycle
  assign in_idle   = state_q == rx_pkg::IDLE;       // every beat here is a header
  assign is_wr     = desc.req_type == `RX_TYPE_MEM_WR;
  assign take_rd   = (desc.req_type == `RX_TYPE_MEM_RD) &&
                     (desc.dw_cnt == `RX_DWCNT_W'(1));
  assign hdr_short = desc.dw_cnt <= `RX_DWCNT_W'(4); // fits in the header beat

  // intake held off while a completion or a flush is pending
  assign tready_o    = (state_q != rx_pkg::READ_WAIT) && (state_q != rx_pkg::FLUSH);
  assign req_compl_o = state_q == rx_pkg::READ_WAIT;

  // pack commands
  assign pack.load_first = beat_ok && in_idle && is_wr;
  assign pack.load_body  = beat_ok && (state_q == rx_pkg::WRITE_BODY);
  // last body word leaves in the flush cycle, carry follows it
  assign pack.flush      = (state_q == rx_pkg::FLUSH) && pack.word_wr;
  assign pack.dw_left    = in_idle ? desc.dw_cnt : dw_left_q;

  ////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////
  always_comb begin
    state_d   = state_q;
    dw_left_d = dw_left_q;
    case (state_q)
      rx_pkg::IDLE: begin
        if (beat_ok) begin
          if (take_rd) begin
            state_d = rx_pkg::READ_WAIT;
          end else if (is_wr) begin
            dw_left_d = desc.dw_cnt;
            if (!hdr_short) state_d = rx_pkg::WRITE_BODY; // more beats follow
          end else if (!tlast_i) begin
            state_d = rx_pkg::DISCARD;                     // odd read or other type
          end
        end
      end
      rx_pkg::READ_WAIT: begin
        if (compl_done_i) state_d = rx_pkg::IDLE;
      end
      rx_pkg::WRITE_BODY: begin
        if (beat_ok) begin
          dw_left_d = dw_left_q - `RX_DWCNT_W'(8);  // one 8-DW word per beat
          if (tlast_i) begin
            // upper half of the last beat still holds payload
            state_d = (dw_left_q > `RX_DWCNT_W'(8)) ? rx_pkg::FLUSH : rx_pkg::IDLE;
          end
        end
      end
      rx_pkg::FLUSH: begin
        if (pack.word_wr) state_d = rx_pkg::IDLE;
      end
      rx_pkg::DISCARD: begin
        if (beat_ok && tlast_i) state_d = rx_pkg::IDLE;
      end
      default: state_d = rx_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= rx_pkg::IDLE;
      dw_left_q <= '0;
    end else begin
      state_q   <= state_d;
      dw_left_q <= dw_left_d;
    end
  end

  ////////////////////////////////////////////////////
  // read descriptor latch
  ////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (beat_ok && in_idle && take_rd) begin
      req_addr_o <= desc.addr[`RX_ADDR_W-1:0];
      req_tc_o   <= desc.tc;
      req_attr_o <= desc.attr;
      req_rid_o  <= desc.req_id;
      req_tag_o  <= desc.tag;
      req_be_o   <= tuser_be_i;
    end
  end

endmodule

`default_nettype wire

// ==== wr_payload_packer.sv ====
// write payload packer
// carries the upper half of each beat and assembles 8-DW fifo words,
// zero-filling every DW slot past the end of the payload
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module wr_payload_packer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rx_pkg::cq_beat_u      beat_i,
  output logic                  fifo_wr_en_o,
  output logic [`RX_DATA_W-1:0] fifo_wr_data_o,
  rx_pack_if.pack               pack
);

  localparam int SLOTS = `RX_DATA_W / 32;  // DWs per fifo word

  logic [`RX_HALF_W-1:0] carry_q;
  logic [`RX_DATA_W-1:0] word_raw;
  logic [`RX_DATA_W-1:0] word_masked;
  logic                  word_go;

  // upper half waits for the next beat's lower half
  always_ff @(posedge clk) begin
    if (pack.load_first || pack.load_body) begin
      carry_q <= beat_i.body.upper;   // header DW0..DW3 or body upper half
    end
  end

  ////////////////////////////////////////////////////
  // word assembly, oldest DWs in the low slots
  ////////////////////////////////////////////////////
  always_comb begin
    word_raw = {beat_i.body.lower, carry_q};  // body beat
    if (pack.load_first) begin
      word_raw = {{`RX_HALF_W{1'b0}}, beat_i.hdr.payload};  // short write
    end else if (pack.flush) begin
      word_raw = {{`RX_HALF_W{1'b0}}, carry_q};
    end
  end

  always_comb begin
    word_masked = word_raw;
    for (int i = 0; i < SLOTS; i++) begin
      if (pack.dw_left <= `RX_DWCNT_W'(i)) word_masked[i*32 +: 32] = '0; // past payload
    end
  end

  // a long write header only fills the carry
  assign word_go = pack.load_body | pack.flush |
                   (pack.load_first && (pack.dw_left <= `RX_DWCNT_W'(4)));

  always_ff @(posedge clk) begin
    if (!rst_n) fifo_wr_en_o <= 1'b0;
    else        fifo_wr_en_o <= word_go;
  end

  always_ff @(posedge clk) begin
    if (word_go) fifo_wr_data_o <= word_masked;
  end

  assign pack.word_wr = fifo_wr_en_o;  // back to the FSM

endmodule

`default_nettype wire

// ==== throughput_window.sv ====
// throughput window
// counts fifo writes over a fixed number of cycles and publishes the total
// with a one-cycle valid pulse at each window end
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module throughput_window #(
  parameter int unsigned WINDOW_CYCLES = `RX_WINDOW_CYCLES
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear_i,        // restarts window and count
  input  logic                 count_en_i,     // fifo write strobe
  output logic [`RX_CNT_W-1:0] total_o,
  output logic                 total_valid_o
);

  logic [`RX_CNT_W-1:0] timer_q;
  logic [`RX_CNT_W-1:0] count_q;
  logic                 wrap;

  assign wrap = timer_q == `RX_CNT_W'(WINDOW_CYCLES - 1);  // last cycle of window

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      timer_q       <= '0;
      count_q       <= '0;
      total_o       <= '0;
      total_valid_o <= 1'b0;
    end else begin
      timer_q       <= wrap ? '0 : timer_q + 1'b1;
      total_valid_o <= wrap;
      if (wrap) begin
        total_o <= count_q;                     // publish, held till next wrap
        count_q <= `RX_CNT_W'(count_en_i);      // wrap-cycle write opens next window
      end else if (count_en_i) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cq_rx_engine.sv ====
// completer-request receive engine, 256-bit request stream
// single-DW read descriptor capture, write payload packing into 8-DW fifo
// words and a windowed fifo write counter
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module cq_rx_engine #(
  parameter int unsigned WINDOW_CYCLES = `RX_WINDOW_CYCLES
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // completer request stream
  input  logic [`RX_DATA_W-1:0] cq_tdata_i,
  input  logic [7:0]            cq_tuser_be_i,
  input  logic                  cq_tvalid_i,
  input  logic                  cq_tlast_i,
  output logic                  cq_tready_o,
  // completion request and read descriptor
  output logic                  req_compl_o,
  input  logic                  compl_done_i,
  output logic [`RX_ADDR_W-1:0] req_addr_o,
  output logic [2:0]            req_tc_o,
  output logic [2:0]            req_attr_o,
  output logic [15:0]           req_rid_o,
  output logic [7:0]            req_tag_o,
  output logic [7:0]            req_be_o,
  // receive fifo
  output logic                  fifo_wr_en_o,
  output logic [`RX_DATA_W-1:0] fifo_wr_data_o,
  // throughput
  input  logic                  tput_clear_i,
  output logic [`RX_CNT_W-1:0]  tput_count_o,
  output logic                  tput_valid_o
);

  rx_pkg::cq_beat_u beat;
  rx_pack_if        pack_if ();

  assign beat = rx_pkg::cq_beat_u'(cq_tdata_i);

  cq_rx_fsm fsm_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat_i       (beat),
    .tuser_be_i   (cq_tuser_be_i),
    .tvalid_i     (cq_tvalid_i),
    .tlast_i      (cq_tlast_i),
    .compl_done_i (compl_done_i),
    .tready_o     (cq_tready_o),
    .req_compl_o  (req_compl_o),
    .req_addr_o   (req_addr_o),
    .req_tc_o     (req_tc_o),
    .req_attr_o   (req_attr_o),
    .req_rid_o    (req_rid_o),
    .req_tag_o    (req_tag_o),
    .req_be_o     (req_be_o),
    .pack         (pack_if.ctrl)
  );

  wr_payload_packer packer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .beat_i         (beat),
    .fifo_wr_en_o   (fifo_wr_en_o),
    .fifo_wr_data_o (fifo_wr_data_o),
    .pack           (pack_if.pack)
  );

  // every fifo write counts toward the window
  throughput_window #(
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) tput_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear_i       (tput_clear_i),
    .count_en_i    (fifo_wr_en_o),
    .total_o       (tput_count_o),
    .total_valid_o (tput_valid_o)
  );

endmodule

`default_nettype wire

// ==== tb_cq_rx_engine.sv ====
// testbench for the completer-request receive engine
// directed tests for read descriptor capture, write packing, discard and
// the throughput window, with a fifo write monitor and a cycle timeout
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module tb_cq_rx_engine;

  localparam int WINDOW = 200;
  localparam int TIMEOUT_CYCLES = 3000;  // about 5x the longest expected run

  logic                  clk;
  logic                  rst_n;
  logic [`RX_DATA_W-1:0] cq_tdata_i;
  logic [7:0]            cq_tuser_be_i;
  logic                  cq_tvalid_i;
  logic                  cq_tlast_i;
  logic                  cq_tready_o;
  logic                  req_compl_o;
  logic                  compl_done_i;
  logic [`RX_ADDR_W-1:0] req_addr_o;
  logic [2:0]            req_tc_o;
  logic [2:0]            req_attr_o;
  logic [15:0]           req_rid_o;
  logic [7:0]            req_tag_o;
  logic [7:0]            req_be_o;
  logic                  fifo_wr_en_o;
  logic [`RX_DATA_W-1:0] fifo_wr_data_o;
  logic                  tput_clear_i;
  logic [`RX_CNT_W-1:0]  tput_count_o;
  logic                  tput_valid_o;

  integer                seed = 52212;
  int                    cycles = 0;
  int                    errors = 0;
  int                    checks = 0;
  int                    tests = 0;
  int                    test_err;
  string                 cur_test;
  logic [31:0]           pay [0:63];     // payload DWs of the current write
  logic [`RX_DATA_W-1:0] wr_q [$];       // words seen on the fifo port
  logic [`RX_DATA_W-1:0] exp_q [$];

  cq_rx_engine #(.WINDOW_CYCLES(WINDOW)) dut_i (
    .clk (clk), .rst_n (rst_n),
    .cq_tdata_i (cq_tdata_i), .cq_tuser_be_i (cq_tuser_be_i),
    .cq_tvalid_i (cq_tvalid_i), .cq_tlast_i (cq_tlast_i), .cq_tready_o (cq_tready_o),
    .req_compl_o (req_compl_o), .compl_done_i (compl_done_i),
    .req_addr_o (req_addr_o), .req_tc_o (req_tc_o), .req_attr_o (req_attr_o),
    .req_rid_o (req_rid_o), .req_tag_o (req_tag_o), .req_be_o (req_be_o),
    .fifo_wr_en_o (fifo_wr_en_o), .fifo_wr_data_o (fifo_wr_data_o),
    .tput_clear_i (tput_clear_i), .tput_count_o (tput_count_o),
    .tput_valid_o (tput_valid_o)
  );

  always #20 clk = ~clk;  // 40 ns period

  // outputs only move on the rising edge, so sample on the falling one
  always @(negedge clk) begin
    if (rst_n && fifo_wr_en_o) wr_q.push_back(fifo_wr_data_o);
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles in test %s", cycles, cur_test);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic check(input string what, input logic [255:0] exp, input logic [255:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_err++;
      $display("Error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test();
    tests++;
    $display("test %-12s finished, %0d mismatches", cur_test, test_err);
  endtask

  // header beat: payload DW0..DW3 above the 128-bit descriptor
  function automatic logic [255:0] make_header(input logic [3:0] req_type,
      input int dw_cnt, input logic [61:0] addr, input logic [2:0] tc,
      input logic [2:0] attr, input logic [15:0] rid, input logic [7:0] tag,
      input logic [127:0] payload);
    rx_pkg::cq_desc_t d;
    d          = '0;
    d.req_type = req_type;
    d.dw_cnt   = dw_cnt[`RX_DWCNT_W-1:0];
    d.addr     = addr;
    d.tc       = tc;
    d.attr     = attr;
    d.req_id   = rid;
    d.tag      = tag;
    return {payload, d};
  endfunction

  function automatic logic [255:0] rand_beat();
    logic [255:0] b;
    int           i;
    for (i = 0; i < 8; i++) b[i*32 +: 32] = $random(seed);
    return b;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_beat(input logic [255:0] data, input logic last, input logic [7:0] be);
    cq_tdata_i    = data;
    cq_tlast_i    = last;
    cq_tuser_be_i = be;
    cq_tvalid_i   = 1'b1;
    while (!cq_tready_o) @(negedge clk);  // held off by READ_WAIT or FLUSH
    @(negedge clk);
    cq_tvalid_i   = 1'b0;
    cq_tlast_i    = 1'b0;
  endtask

  task automatic wait_valid(input int limit);
    int i;
    i = 0;
    while (!tput_valid_o && i < limit) begin
      @(negedge clk);
      i++;
    end
    if (!tput_valid_o) begin
      errors++;
      test_err++;
      $display("%s: tput_valid_o did not pulse within %0d cycles", cur_test, limit);
    end
  endtask

  //////////////////////////////////////////////////
  // one write of len DWs, random gaps between beats, then compare words
  //////////////////////////////////////////////////
  task automatic run_write(input int len, input int max_gap);
    logic [255:0] beat;
    logic [255:0] exp;
    int           nbody;
    int           nwords;
    int           gap;
    int           i;
    int           k;
    int           n;
    wr_q.delete();
    exp_q.delete();
    for (i = 0; i < 64; i++) pay[i] = $random(seed);  // DWs past len act as junk
    nbody  = (len > 4) ? (len - 4 + 7) / 8 : 0;       // header holds DW0..DW3
    nwords = (len + 7) / 8;
    beat   = make_header(`RX_TYPE_MEM_WR, len, 62'($random(seed)), 3'd0, 3'd0,
                         16'd0, 8'($random(seed)), {pay[3], pay[2], pay[1], pay[0]});
    send_beat(beat, nbody == 0, 8'h00);
    for (k = 1; k <= nbody; k++) begin
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) @(negedge clk);                    // tvalid low
      for (i = 0; i < 8; i++) beat[i*32 +: 32] = pay[8*k - 4 + i];
      send_beat(beat, k == nbody, 8'h00);
    end
    // packing rule: DW n in word n/8, slot n mod 8, zero past len
    for (k = 0; k < nwords; k++) begin
      for (i = 0; i < 8; i++) begin
        n = 8*k + i;
        exp[i*32 +: 32] = (n < len) ? pay[n] : 32'd0;
      end
      exp_q.push_back(exp);
    end
    i = 0;
    while (wr_q.size() < nwords && i < 20) begin
      @(negedge clk);
      i++;
    end
    repeat (2) @(negedge clk);  // catch any extra word
    check($sformatf("len %0d word count", len), nwords, wr_q.size());
    for (k = 0; k < nwords && k < wr_q.size(); k++) begin
      check($sformatf("len %0d word %0d", len, k), exp_q[k], wr_q[k]);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_reset_state();
    start_test("reset_state");
    check("tready", 1, cq_tready_o);
    check("req_compl", 0, req_compl_o);
    check("fifo_wr_en", 0, fifo_wr_en_o);
    check("tput_valid", 0, tput_valid_o);
    end_test();
  endtask

  task automatic test_read_desc();
    logic [31:0] addr;
    logic [2:0]  tc;
    logic [2:0]  attr;
    logic [15:0] rid;
    logic [7:0]  tag;
    logic [7:0]  be;
    int          delay;
    start_test("read_desc");
    addr  = $random(seed);
    tc    = $random(seed);
    attr  = $random(seed);
    rid   = $random(seed);
    tag   = $random(seed);
    be    = $random(seed);
    delay = 2 + $unsigned($random(seed)) % 8;
    send_beat(make_header(`RX_TYPE_MEM_RD, 1, {30'd0, addr}, tc, attr, rid, tag,
                          {4{addr}}), 1'b1, be);
    check("req_compl", 1, req_compl_o);
    check("tready", 0, cq_tready_o);
    check("addr", addr[`RX_ADDR_W-1:0], req_addr_o);  // low DW address bits only
    check("tc", tc, req_tc_o);
    check("attr", attr, req_attr_o);
    check("rid", rid, req_rid_o);
    check("tag", tag, req_tag_o);
    check("be", be, req_be_o);
    repeat (delay) begin
      @(negedge clk);
      check("tready held", 0, cq_tready_o);
      check("req_compl held", 1, req_compl_o);
    end
    compl_done_i = 1'b1;
    @(negedge clk);
    compl_done_i = 1'b0;
    check("tready after done", 1, cq_tready_o);
    check("req_compl after done", 0, req_compl_o);
    end_test();
  endtask

  task automatic test_short_writes();
    int len;
    start_test("short_write");
    for (len = 1; len <= 4; len++) run_write(len, 0);
    end_test();
  endtask

  task automatic test_long_writes();
    start_test("long_write");
    run_write(5, 3);
    run_write(8, 3);
    run_write(12, 3);   // ends in a flush
    run_write(21, 3);
    end_test();
  endtask

  task automatic test_discard();
    start_test("discard");
    wr_q.delete();
    // read of two DWs, three beats
    send_beat(make_header(`RX_TYPE_MEM_RD, 2, 62'h40, 3'd0, 3'd0, 16'h1, 8'h5,
                          128'd0), 1'b0, 8'hff);
    check("req_compl rd2 hdr", 0, req_compl_o);
    send_beat(rand_beat(), 1'b0, 8'h00);
    send_beat(rand_beat(), 1'b1, 8'h00);
    check("req_compl rd2 end", 0, req_compl_o);
    // other request type, two beats
    send_beat(make_header(4'd3, 1, 62'h80, 3'd0, 3'd0, 16'h2, 8'h6, 128'd0), 1'b0, 8'h0f);
    send_beat(rand_beat(), 1'b1, 8'h00);
    repeat (3) @(negedge clk);
    check("req_compl other", 0, req_compl_o);
    check("writes while discarding", 0, wr_q.size());
    run_write(1, 0);
    end_test();
  endtask

  task automatic test_throughput();
    start_test("throughput");
    tput_clear_i = 1'b1;
    @(negedge clk);
    tput_clear_i = 1'b0;
    run_write(21, 1);   // 3 words
    run_write(12, 1);   // 2 words
    run_write(4, 0);
    run_write(1, 0);
    wait_valid(WINDOW + 50);
    check("window count", 7, tput_count_o);
    @(negedge clk);
    wait_valid(WINDOW + 50);
    check("idle window count", 0, tput_count_o);
    end_test();
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    cq_tdata_i    = '0;
    cq_tuser_be_i = '0;
    cq_tvalid_i   = 1'b0;
    cq_tlast_i    = 1'b0;
    compl_done_i  = 1'b0;
    tput_clear_i  = 1'b0;
    cur_test      = "reset";
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_read_desc();
    test_short_writes();
    test_long_writes();
    test_discard();
    test_throughput();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
rx_pkg.sv
rx_pack_if.sv
cq_rx_fsm.sv
wr_payload_packer.sv
throughput_window.sv
cq_rx_engine.sv
tb_cq_rx_engine.sv

// ==== Bender.yml ====
package:
  name: cq_rx_engine

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rx_pkg.sv
      - rx_pack_if.sv
      - cq_rx_fsm.sv
      - wr_payload_packer.sv
      - throughput_window.sv
      - cq_rx_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cq_rx_engine.sv
